// ==== vlog.f ====
+incdir+source
source/isa_pkg.sv
source/bus_pkg.sv
source/hazard_unit.sv
source/instr_decoder.sv
source/mem_arbiter.sv
source/pipeline_core.sv
source/cpu_top.sv
tests/tb_memory.sv
tests/cpu_tb.sv

// ==== Makefile ====
SOURCES = $(wildcard source/*.sv source/*.svh tests/*.sv)

obj_dir/Vcpu_tb: vlog.f $(SOURCES)
	verilator --binary --timing -f vlog.f --top-module cpu_tb -Mdir obj_dir -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tests/cpu_tb.sv ====
// testbench for the pipelined cpu, assembles a hazard-heavy program
// runs an instruction-set model and checks the store stream on the bus
`timescale 1ns/100ps
`include "core_macros.svh"

module cpu_tb;
	logic clk, rstN;
	logic memReq, memWe, memReady;
	bus_pkg::memAddr_t memAddr;
	isa_pkg::word_t memWData, memRData;
	// owner of the bus, names logged cycles
	bus_pkg::arbState_t busOwner;

	// program image and expected store stream
	isa_pkg::word_t prog [$];
	bus_pkg::memAddr_t expAddr [$];
	isa_pkg::word_t expData [$];
	bus_pkg::memAddr_t haltAddr;
	isa_pkg::regAddr_t regBase, regA, regB, regC, regD, regE, regF, regJ;

	int valueErrors, storeErrors, storeIdx, haltFetches, cycles, cycleLimit;
	logic firstReqSeen, timedOut;

	cpu_top UUT (
		.clk, .rstN, .memReq, .memWe, .memAddr, .memWData, .memRData, .memReady
	);

	tb_memory memModel (
		.clk, .memReq, .memWe, .memAddr, .memWData, .memRData, .memReady
	);

	assign busOwner = UUT.uArbiter.state;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// words the program leaves alone, pattern over the whole address
	function automatic isa_pkg::word_t fillWord(input int addr);
		return 32'h3c5a_0000 ^ (isa_pkg::word_t'(addr) * 32'h0001_0101);
	endfunction

	function automatic isa_pkg::word_t rType(input isa_pkg::opcode_t fn,
			input isa_pkg::regAddr_t rd, rs, rt);
		return {isa_pkg::opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic isa_pkg::word_t iType(input isa_pkg::opcode_t op,
			input isa_pkg::regAddr_t rt, rs, input int imm);
		return {op, rs, rt, imm[15:0]};
	endfunction

	task automatic compareValue(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			valueErrors++;
			$display("Mismatch at %0t ns: %s, expected %h, got %h",
				$time, what, expected, got);
		end
	endtask

	// skipped words store a marker, seen on the bus only if wrongly run
	task automatic addMarkers(input int n);
		for (int i = 0; i < n; i++)
			prog.push_back(iType(isa_pkg::opSw, regA, regBase, 256 + 4 * i));
	endtask

	task automatic branchOver(input isa_pkg::opcode_t op,
			input isa_pkg::regAddr_t rs, rt, input int skip);
		prog.push_back(iType(op, rt, rs, skip));
		addMarkers(skip);
	endtask

	task automatic jumpOver(input int skip);
		prog.push_back({isa_pkg::opJ, 26'(prog.size() + 1 + skip)});
		addMarkers(skip);
	endtask

	// jr register holds the target as a byte address
	task automatic jrOver(input int skip);
		prog.push_back(iType(isa_pkg::opAddi, regJ, 5'd0, (prog.size() + 2 + skip) * 4));
		prog.push_back(rType(isa_pkg::fnJr, 5'd0, regJ, 5'd0));
		addMarkers(skip);
	endtask

	// distinct random registers, never register 0
	task automatic pickRegisters();
		isa_pkg::regAddr_t pool [31];
		isa_pkg::regAddr_t tmp;
		int j;
		for (int i = 0; i < 31; i++)
			pool[i] = isa_pkg::regAddr_t'(i + 1);
		for (int i = 30; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			tmp = pool[i];
			pool[i] = pool[j];
			pool[j] = tmp;
		end
		regBase = pool[0];
		regA = pool[1];
		regB = pool[2];
		regC = pool[3];
		regD = pool[4];
		regE = pool[5];
		regF = pool[6];
		regJ = pool[7];
	endtask

	task automatic assembleProgram();
		int immA, immB, immC, immE, loadOff;
		immA = int'($urandom_range(2000, 0)) - 1000;
		// immB never equals immA, keeps the beq on them untaken
		immB = immA + 1 + int'($urandom_range(500, 0));
		immC = int'($urandom_range(300, 1));
		immE = int'($urandom_range(100, 1));
		loadOff = 4 * int'($urandom_range(200, 100));
		pickRegisters();
		prog.delete();
		// data region at word 512
		prog.push_back(iType(isa_pkg::opAddi, regBase, 5'd0, 2048));
		prog.push_back(iType(isa_pkg::opAddi, regA, 5'd0, immA));
		prog.push_back(iType(isa_pkg::opAddi, regB, 5'd0, immB));
		// dependent alu ops at distance 1 and 2
		prog.push_back(rType(isa_pkg::fnAdd, regC, regA, regB));
		prog.push_back(rType(isa_pkg::fnSub, regD, regC, regA));
		prog.push_back(iType(isa_pkg::opSw, regC, regBase, 0));
		prog.push_back(iType(isa_pkg::opSw, regD, regBase, 4));
		prog.push_back(rType(isa_pkg::fnAnd, regE, regC, regD));
		prog.push_back(rType(isa_pkg::fnOr, regF, regE, regA));
		prog.push_back(rType(isa_pkg::fnSlt, regE, regF, regB));
		prog.push_back(iType(isa_pkg::opSw, regE, regBase, 8));
		prog.push_back(iType(isa_pkg::opSw, regF, regBase, 12));
		// write to register 0, read right after
		prog.push_back(rType(isa_pkg::fnAdd, 5'd0, regA, regB));
		prog.push_back(rType(isa_pkg::fnAdd, regE, 5'd0, regA));
		prog.push_back(iType(isa_pkg::opSw, regE, regBase, 16));
		prog.push_back(iType(isa_pkg::opSw, 5'd0, regBase, 20));
		// load-use, then a load of a filled word
		prog.push_back(iType(isa_pkg::opLw, regE, regBase, 0));
		prog.push_back(iType(isa_pkg::opAddi, regF, regE, immC));
		prog.push_back(iType(isa_pkg::opSw, regF, regBase, 24));
		prog.push_back(iType(isa_pkg::opLw, regE, regBase, loadOff));
		prog.push_back(rType(isa_pkg::fnAdd, regF, regE, regE));
		prog.push_back(iType(isa_pkg::opSw, regF, regBase, 28));
		// store, reload, store the loaded word straight away
		prog.push_back(iType(isa_pkg::opSw, regA, regBase, 32));
		prog.push_back(iType(isa_pkg::opLw, regE, regBase, 32));
		prog.push_back(iType(isa_pkg::opSw, regE, regBase, 36));
		// taken beq, then bne on the previous alu result
		branchOver(isa_pkg::opBeq, regA, regA, 1);
		prog.push_back(iType(isa_pkg::opAddi, regE, 5'd0, immE));
		branchOver(isa_pkg::opBne, regE, 5'd0, 1);
		// untaken beq on an alu result, next store must appear
		prog.push_back(iType(isa_pkg::opAddi, regE, regA, 0));
		prog.push_back(iType(isa_pkg::opBeq, regB, regE, 1));
		prog.push_back(iType(isa_pkg::opSw, regE, regBase, 40));
		// branches on loaded values
		prog.push_back(iType(isa_pkg::opLw, regF, regBase, 0));
		prog.push_back(iType(isa_pkg::opBne, regC, regF, 1));
		prog.push_back(iType(isa_pkg::opSw, regF, regBase, 44));
		prog.push_back(iType(isa_pkg::opLw, regF, regBase, 4));
		branchOver(isa_pkg::opBeq, regF, regD, 1);
		// branch operand from the memory stage
		prog.push_back(rType(isa_pkg::fnAdd, regE, regA, regB));
		prog.push_back(iType(isa_pkg::opSw, regB, regBase, 48));
		branchOver(isa_pkg::opBeq, regE, regC, 1);
		jumpOver(1);
		jrOver(1);
		prog.push_back(iType(isa_pkg::opSw, regA, regBase, 52));
		prog.push_back(iType(isa_pkg::opBne, regA, regA, 1));
		prog.push_back(iType(isa_pkg::opSw, regB, regBase, 56));
		prog.push_back(rType(isa_pkg::fnAdd, regE, regA, regA));
		prog.push_back(iType(isa_pkg::opSw, regE, regBase, 60));
		// halt loop
		haltAddr = bus_pkg::memAddr_t'(prog.size());
		prog.push_back({isa_pkg::opJ, 26'(prog.size())});
	endtask

	// instruction-set model, one instruction per step, stores in program order
	function automatic void runModel();
		isa_pkg::word_t regs [`REG_COUNT];
		isa_pkg::word_t ram [`MEM_WORDS];
		isa_pkg::word_t ins, a, b, imm;
		bus_pkg::memAddr_t addr;
		int pc, nextPc, steps;
		logic halted;
		for (int i = 0; i < `REG_COUNT; i++)
			regs[i] = '0;
		for (int i = 0; i < `MEM_WORDS; i++)
			ram[i] = (i < prog.size()) ? prog[i] : fillWord(i);
		pc = `RESET_PC;
		steps = 0;
		halted = 1'b0;
		while (!halted && steps < 10000) begin
			ins = ram[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			// byte address in registers, word address in memory
			addr = bus_pkg::memAddr_t'((a + imm) >> 2);
			nextPc = pc + 1;
			case (ins[31:26])
				isa_pkg::opRType:
					case (ins[5:0])
						isa_pkg::fnAdd: regs[ins[15:11]] = a + b;
						isa_pkg::fnSub: regs[ins[15:11]] = a - b;
						isa_pkg::fnAnd: regs[ins[15:11]] = a & b;
						isa_pkg::fnOr: regs[ins[15:11]] = a | b;
						isa_pkg::fnSlt: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						isa_pkg::fnJr: nextPc = int'(bus_pkg::memAddr_t'(a >> 2));
						default: ;
					endcase
				isa_pkg::opAddi: regs[ins[20:16]] = a + imm;
				isa_pkg::opLw: regs[ins[20:16]] = ram[addr];
				isa_pkg::opSw: begin
					ram[addr] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				isa_pkg::opBeq: if (a == b) nextPc = pc + 1 + int'($signed(imm));
				isa_pkg::opBne: if (a != b) nextPc = pc + 1 + int'($signed(imm));
				isa_pkg::opJ: nextPc = int'(ins[`MEM_AW-1:0]);
				default: ;
			endcase
			regs[0] = '0;
			halted = (nextPc == pc);
			pc = nextPc % `MEM_WORDS;
			steps++;
		end
	endfunction

	// bus sampled mid low phase, after the memory has answered
	initial begin
		forever begin
			@(negedge clk);
			#10;
			if (!rstN) begin
				compareValue("memReq during reset", 32'(memReq), 32'd0);
			end else if (memReq && !firstReqSeen) begin
				firstReqSeen = 1'b1;
				compareValue("first fetch address", 32'(memAddr), 32'(`RESET_PC));
			end
			if (memReq && memReady && memWe) begin
				if (storeIdx >= expAddr.size()) begin
					storeErrors++;
					$display("Extra store at %0t ns to word %0d in %s cycle, none was expected",
						$time, memAddr, busOwner.name());
				end else begin
					compareValue($sformatf("store %0d address", storeIdx),
						32'(memAddr), 32'(expAddr[storeIdx]));
					compareValue($sformatf("store %0d data", storeIdx),
						memWData, expData[storeIdx]);
				end
				storeIdx++;
			end else if (memReq && memReady && memAddr == haltAddr) begin
				haltFetches++;
			end
		end
	end

	initial begin
		void'($urandom(78042));
		rstN = 1'b0;
		valueErrors = 0;
		storeErrors = 0;
		storeIdx = 0;
		haltFetches = 0;
		cycles = 0;
		firstReqSeen = 1'b0;
		timedOut = 1'b0;
		assembleProgram();
		for (int i = 0; i < `MEM_WORDS; i++)
			memModel.mem[i] = (i < prog.size()) ? prog[i] : fillWord(i);
		runModel();
		cycleLimit = 40 * prog.size() * 4;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		// several halt fetches mean every earlier store has left the pipe
		while (haltFetches < 4 && !timedOut) begin
			@(negedge clk);
			cycles++;
			if (cycles >= cycleLimit)
				timedOut = 1'b1;
		end
		if (timedOut) begin
			$display("Timeout: halt loop not reached within %0d cycles", cycleLimit);
		end else if (storeIdx < expAddr.size()) begin
			storeErrors++;
			$display("Missing stores: saw %0d of %0d expected stores", storeIdx, expAddr.size());
		end
		$display("Errors: %0d value mismatches, %0d store count errors, %0d timeouts",
			valueErrors, storeErrors, int'(timedOut));
		if (timedOut || valueErrors != 0 || storeErrors != 0)
			$display("test failed");
		else
			$display("test passed");
		$finish;
	end
endmodule : cpu_tb

// ==== tests/tb_memory.sv ====
// behavioral memory on the shared bus
// answers each request after a random delay of 0 to 3 cycles
`timescale 1ns/100ps
`include "core_macros.svh"

module tb_memory (
	input  logic clk,
	input  logic memReq, memWe,
	input  bus_pkg::memAddr_t memAddr,
	input  isa_pkg::word_t memWData,
	output isa_pkg::word_t memRData,
	output logic memReady
);
	// program and data share one array, loaded by the testbench
	isa_pkg::word_t mem [`MEM_WORDS];
	logic busy;
	int delayLeft;

	initial begin
		memRData = '0;
		memReady = 1'b0;
		busy = 1'b0;
		delayLeft = 0;
	end

	// bus outputs of the cpu change on the rising edge, settled here
	always @(negedge clk) begin
		memReady = 1'b0;
		if (memReq) begin
			// new access once the previous one has completed
			if (!busy) begin
				busy = 1'b1;
				delayLeft = int'($urandom_range(3, 0));
			end
			if (delayLeft == 0) begin
				// one-cycle ready, read word valid with it
				memReady = 1'b1;
				memRData = mem[memAddr];
				if (memWe)
					mem[memAddr] = memWData;
				busy = 1'b0;
			end else begin
				delayLeft = delayLeft - 1;
			end
		end
	end
endmodule : tb_memory

// ==== source/cpu_top.sv ====
// processor top: pipeline, decoder, hazard unit and bus arbiter
// on one external memory bus
`timescale 1ns/100ps

module cpu_top (
	input  logic clk, rstN,
	output logic memReq, memWe,
	output bus_pkg::memAddr_t memAddr,
	output isa_pkg::word_t memWData,
	input  isa_pkg::word_t memRData,
	input  logic memReady
);
	// core and arbiter
	isa_pkg::word_t iData, dRData, dWData;
	bus_pkg::memAddr_t iAddr, dAddr;
	logic dWe, Iwait, Dwait, memaccessM;
	// decoder
	isa_pkg::word_t instrD;
	logic regwriteD, memtoregD, memwriteD, aluSrcD, regDstD;
	logic branchD, branchNeD, jumpD, jrD;
	isa_pkg::aluOp_t aluOpD;
	// hazard unit
	isa_pkg::regAddr_t rsD, rtD, rsE, rtE, writeregE, writeregM, writeregW;
	logic memtoregE, memtoregM, memwriteM, regwriteE, regwriteM, regwriteW;
	logic br_takenD, forwardAD, forwardBD;
	logic [1:0] forwardAE, forwardBE;
	logic stallF, stallD, stallE, stallM, stallW, flushD, flushE;

	pipeline_core uCore (
		.clk, .rstN, .iData, .dRData, .iAddr, .dAddr, .dWData, .dWe, .instrD,
		.regwrite(regwriteD), .memtoreg(memtoregD), .memwrite(memwriteD),
		.branch(branchD), .branchNe(branchNeD), .jump(jumpD), .jr(jrD),
		.aluSrc(aluSrcD), .regDst(regDstD), .aluOp(aluOpD),
		.forwardAD, .forwardBD, .forwardAE, .forwardBE,
		.stallF, .stallD, .stallE, .stallM, .stallW, .flushD, .flushE,
		.rsD, .rtD, .rsE, .rtE, .writeregE, .writeregM, .writeregW,
		.memtoregE, .memtoregM, .memwriteM, .regwriteE, .regwriteM, .regwriteW,
		.br_takenD
	);

	instr_decoder uDecoder (
		.instrD, .regwrite(regwriteD), .memtoreg(memtoregD), .memwrite(memwriteD),
		.branch(branchD), .branchNe(branchNeD), .jump(jumpD), .jr(jrD),
		.aluSrc(aluSrcD), .regDst(regDstD), .aluOp(aluOpD)
	);

	hazard_unit uHazard (
		.Iwait, .Dwait, .branchD, .jumpD, .jrD, .br_takenD,
		.memtoregE, .regwriteE, .memtoregM, .regwriteM, .memwriteM, .regwriteW,
		.rsD, .rtD, .rsE, .rtE, .writeregE, .writeregM, .writeregW,
		.forwardAD, .forwardBD, .forwardAE, .forwardBE,
		.stallF, .stallD, .stallE, .stallM, .stallW, .flushD, .flushE, .memaccessM
	);

	// fetch requests whenever the core is out of reset
	mem_arbiter uArbiter (
		.clk, .rstN, .iReq(rstN), .dReq(memaccessM), .dWe, .iAddr, .dAddr, .dWData,
		.iData, .dRData, .Iwait, .Dwait, .memReq, .memWe, .memAddr, .memWData,
		.memRData, .memReady
	);
endmodule : cpu_top

// ==== source/pipeline_core.sv ====
// five-stage integer pipeline: fetch, decode, execute, memory, writeback
// pc, register file, alu, stage registers and decode-stage branch resolve
`timescale 1ns/100ps
`include "core_macros.svh"

module pipeline_core (
	input  logic clk, rstN,
	// memory ports, pc and data address are word addresses
	input  isa_pkg::word_t iData, dRData,
	output bus_pkg::memAddr_t iAddr, dAddr,
	output isa_pkg::word_t dWData,
	output logic dWe,
	// decoder
	output isa_pkg::word_t instrD,
	input  logic regwrite, memtoreg, memwrite,
	input  logic branch, branchNe, jump, jr,
	input  logic aluSrc, regDst,
	input  isa_pkg::aluOp_t aluOp,
	// hazard unit
	input  logic forwardAD, forwardBD,
	input  logic [1:0] forwardAE, forwardBE,
	input  logic stallF, stallD, stallE, stallM, stallW,
	input  logic flushD, flushE,
	output isa_pkg::regAddr_t rsD, rtD, rsE, rtE,
	output isa_pkg::regAddr_t writeregE, writeregM, writeregW,
	output logic memtoregE, memtoregM, memwriteM,
	output logic regwriteE, regwriteM, regwriteW,
	output logic br_takenD
);
	// fetch
	bus_pkg::memAddr_t pcF, pcPlus1F, pcNextF;
	// decode
	bus_pkg::memAddr_t pcPlus1D, brTargetD, jTargetD, jrTargetD;
	isa_pkg::regAddr_t rdD, writeregD;
	isa_pkg::word_t immD, rd1D, rd2D, srcAD, srcBD;
	isa_pkg::word_t regFile [`REG_COUNT];
	// execute
	logic memwriteE, aluSrcE;
	isa_pkg::aluOp_t aluOpE;
	isa_pkg::word_t rd1E, rd2E, immE, srcAE, srcBE, writeDataE, aluOutE;
	// memory and writeback
	isa_pkg::word_t aluOutM, writeDataM;
	logic memtoregW;
	isa_pkg::word_t aluOutW, readDataW, resultW;

	assign pcPlus1F = pcF + 1'b1;
	assign iAddr = pcF;

	// redirects only land when fetch advances, so decode is resolved then
	always_comb begin
		if (jr)
			pcNextF = jrTargetD;
		else if (jump)
			pcNextF = jTargetD;
		else if (br_takenD)
			pcNextF = brTargetD;
		else
			pcNextF = pcPlus1F;
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			pcF <= bus_pkg::memAddr_t'(`RESET_PC);
		else if (!stallF)
			pcF <= pcNextF;
	end

	// F/D, an all-zero word decodes as a no-op
	always_ff @(posedge clk) begin
		if (!rstN || (flushD && !stallD))
			instrD <= '0;
		else if (!stallD)
			instrD <= iData;
	end

	always_ff @(posedge clk) begin
		if (!stallD)
			pcPlus1D <= pcPlus1F;
	end

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = {{(`DATA_W-16){instrD[15]}}, instrD[15:0]};
	assign writeregD = regDst ? rdD : rtD;

	// register file, contents undefined until written
	always_ff @(posedge clk) begin
		if (regwriteW && writeregW != '0)
			regFile[writeregW] <= resultW;
	end

	// read-through gives decode the value written this cycle
	assign rd1D = (rsD == '0) ? '0 :
		(regwriteW && writeregW == rsD) ? resultW : regFile[rsD];
	assign rd2D = (rtD == '0) ? '0 :
		(regwriteW && writeregW == rtD) ? resultW : regFile[rtD];

	// branch compare after the memory-stage bypass
	assign srcAD = forwardAD ? aluOutM : rd1D;
	assign srcBD = forwardBD ? aluOutM : rd2D;
	assign br_takenD = branch && ((srcAD == srcBD) != branchNe);

	// branch offset and j field count words, jr register holds a byte address
	assign brTargetD = pcPlus1D + immD[`MEM_AW-1:0];
	assign jTargetD = instrD[`MEM_AW-1:0];
	assign jrTargetD = srcAD[`MEM_AW+1:2];

	// D/E, bubble clears the write enables
	always_ff @(posedge clk) begin
		if (!rstN || (flushE && !stallE)) begin
			regwriteE <= 1'b0;
			memtoregE <= 1'b0;
			memwriteE <= 1'b0;
		end else if (!stallE) begin
			regwriteE <= regwrite;
			memtoregE <= memtoreg;
			memwriteE <= memwrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			aluSrcE <= aluSrc;
			aluOpE <= aluOp;
			rd1E <= rd1D;
			rd2E <= rd2D;
			immE <= immD;
			rsE <= rsD;
			rtE <= rtD;
			writeregE <= writeregD;
		end
	end

	always_comb begin
		case (forwardAE)
			isa_pkg::fwdResultW: srcAE = resultW;
			isa_pkg::fwdAluOutM: srcAE = aluOutM;
			default: srcAE = rd1E;
		endcase
		// store data takes the same bypass as operand b
		case (forwardBE)
			isa_pkg::fwdResultW: writeDataE = resultW;
			isa_pkg::fwdAluOutM: writeDataE = aluOutM;
			default: writeDataE = rd2E;
		endcase
	end

	assign srcBE = aluSrcE ? immE : writeDataE;

	always_comb begin
		case (aluOpE)
			isa_pkg::aluSub: aluOutE = srcAE - srcBE;
			isa_pkg::aluAnd: aluOutE = srcAE & srcBE;
			isa_pkg::aluOr: aluOutE = srcAE | srcBE;
			// signed compare
			isa_pkg::aluSlt: aluOutE = isa_pkg::word_t'($signed(srcAE) < $signed(srcBE));
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	// E/M
	always_ff @(posedge clk) begin
		if (!rstN) begin
			regwriteM <= 1'b0;
			memtoregM <= 1'b0;
			memwriteM <= 1'b0;
		end else if (!stallM) begin
			regwriteM <= regwriteE;
			memtoregM <= memtoregE;
			memwriteM <= memwriteE;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallM) begin
			aluOutM <= aluOutE;
			writeDataM <= writeDataE;
			writeregM <= writeregE;
		end
	end

	// byte address from the alu, word address on the bus
	assign dAddr = aluOutM[`MEM_AW+1:2];
	assign dWData = writeDataM;
	assign dWe = memwriteM;

	// M/W, load data captured in its ready cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			regwriteW <= 1'b0;
			memtoregW <= 1'b0;
		end else if (!stallW) begin
			regwriteW <= regwriteM;
			memtoregW <= memtoregM;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallW) begin
			aluOutW <= aluOutM;
			readDataW <= dRData;
			writeregW <= writeregM;
		end
	end

	assign resultW = memtoregW ? readDataW : aluOutW;
endmodule : pipeline_core

// ==== source/mem_arbiter.sv ====
// memory bus arbiter: one access at a time, data before instruction
// returns the read word and a wait to each requester
`timescale 1ns/100ps

module mem_arbiter (
	input  logic clk, rstN,
	input  logic iReq, dReq, dWe,
	input  bus_pkg::memAddr_t iAddr, dAddr,
	input  isa_pkg::word_t dWData,
	output isa_pkg::word_t iData, dRData,
	output logic Iwait, Dwait,
	output logic memReq, memWe,
	output bus_pkg::memAddr_t memAddr,
	output isa_pkg::word_t memWData,
	input  isa_pkg::word_t memRData,
	input  logic memReady
);
	bus_pkg::arbState_t state, stateNext;
	logic iDone, dDone;

	assign iDone = (state == bus_pkg::arbInstr) && memReady;
	assign dDone = (state == bus_pkg::arbData) && memReady;

	always_comb begin
		stateNext = state;
		case (state)
			bus_pkg::arbIdle:
				if (dReq)
					stateNext = bus_pkg::arbData;
				else if (iReq)
					stateNext = bus_pkg::arbInstr;
			// after a fetch the data side is a separate pending request
			bus_pkg::arbInstr:
				if (memReady)
					stateNext = dReq ? bus_pkg::arbData :
						iReq ? bus_pkg::arbInstr : bus_pkg::arbIdle;
			// the completing dReq belongs to the access just finished
			bus_pkg::arbData:
				if (memReady)
					stateNext = iReq ? bus_pkg::arbInstr : bus_pkg::arbIdle;
			default: stateNext = bus_pkg::arbIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			state <= bus_pkg::arbIdle;
		else
			state <= stateNext;
	end

	// bus side, address held by the stalled requester
	assign memReq = (state != bus_pkg::arbIdle);
	assign memAddr = (state == bus_pkg::arbData) ? dAddr : iAddr;
	assign memWe = (state == bus_pkg::arbData) && dWe;
	assign memWData = dWData;

	// read word valid in the completion cycle only
	assign iData = memRData;
	assign dRData = memRData;
	assign Iwait = iReq && !iDone;
	assign Dwait = dReq && !dDone;
endmodule : mem_arbiter

// ==== source/instr_decoder.sv ====
// instruction decoder: opcode and funct to datapath control levels
`timescale 1ns/100ps

module instr_decoder (
	input  isa_pkg::word_t instrD,
	output logic regwrite, memtoreg, memwrite,
	output logic branch, branchNe, jump, jr,
	output logic aluSrc, regDst,
	output isa_pkg::aluOp_t aluOp
);
	isa_pkg::opcode_t opcode, funct;

	assign opcode = instrD[31:26];
	assign funct = instrD[5:0];

	always_comb begin
		// unknown encodings fall out as a no-op
		regwrite = 1'b0;
		memtoreg = 1'b0;
		memwrite = 1'b0;
		branch = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		jr = 1'b0;
		aluSrc = 1'b0;
		regDst = 1'b0;
		aluOp = isa_pkg::aluAdd;

		case (opcode)
			isa_pkg::opRType: begin
				regDst = 1'b1;
				case (funct)
					isa_pkg::fnAdd: regwrite = 1'b1;
					isa_pkg::fnSub: begin
						regwrite = 1'b1;
						aluOp = isa_pkg::aluSub;
					end
					isa_pkg::fnAnd: begin
						regwrite = 1'b1;
						aluOp = isa_pkg::aluAnd;
					end
					isa_pkg::fnOr: begin
						regwrite = 1'b1;
						aluOp = isa_pkg::aluOr;
					end
					isa_pkg::fnSlt: begin
						regwrite = 1'b1;
						aluOp = isa_pkg::aluSlt;
					end
					isa_pkg::fnJr: jr = 1'b1;
					default: regDst = 1'b0;
				endcase
			end
			// immediate forms add rs and the sign-extended offset
			isa_pkg::opAddi: begin
				regwrite = 1'b1;
				aluSrc = 1'b1;
			end
			isa_pkg::opLw: begin
				regwrite = 1'b1;
				memtoreg = 1'b1;
				aluSrc = 1'b1;
			end
			isa_pkg::opSw: begin
				memwrite = 1'b1;
				aluSrc = 1'b1;
			end
			isa_pkg::opBeq: branch = 1'b1;
			isa_pkg::opBne: begin
				branch = 1'b1;
				branchNe = 1'b1;
			end
			isa_pkg::opJ: jump = 1'b1;
			default: regwrite = 1'b0;
		endcase
	end
endmodule : instr_decoder

// ==== source/hazard_unit.sv ====
// hazard unit: bypass selects, load-use and branch stalls,
// memory freeze and per-stage stall and flush controls
`timescale 1ns/100ps

module hazard_unit (
	input  logic Iwait, Dwait,
	input  logic branchD, jumpD, jrD, br_takenD,
	input  logic memtoregE, regwriteE,
	input  logic memtoregM, regwriteM, memwriteM,
	input  logic regwriteW,
	input  isa_pkg::regAddr_t rsD, rtD, rsE, rtE,
	input  isa_pkg::regAddr_t writeregE, writeregM, writeregW,
	output logic forwardAD, forwardBD,
	output logic [1:0] forwardAE, forwardBE,
	output logic stallF, stallD, stallE, stallM, stallW,
	output logic flushD, flushE,
	output logic memaccessM
);
	logic lwstall, branchstall, memstall, redirectWait, holdD;

	// execute bypass, memory stage wins over writeback
	always_comb begin
		if (rsE != '0 && rsE == writeregM && regwriteM)
			forwardAE = isa_pkg::fwdAluOutM;
		else if (rsE != '0 && rsE == writeregW && regwriteW)
			forwardAE = isa_pkg::fwdResultW;
		else
			forwardAE = isa_pkg::fwdReg;

		if (rtE != '0 && rtE == writeregM && regwriteM)
			forwardBE = isa_pkg::fwdAluOutM;
		else if (rtE != '0 && rtE == writeregW && regwriteW)
			forwardBE = isa_pkg::fwdResultW;
		else
			forwardBE = isa_pkg::fwdReg;
	end

	// decode bypass for the branch compare and jr target
	// writeback values come through the register file read
	assign forwardAD = (rsD != '0) && (rsD == writeregM) && regwriteM;
	assign forwardBD = (rtD != '0) && (rtD == writeregM) && regwriteM;

	always_comb begin
		// data access pending in memory stage
		memaccessM = memtoregM | memwriteM;
		memstall = Dwait & memaccessM;

		// load in execute feeding the instruction in decode
		lwstall = memtoregE && ((writeregE == rsD) || (writeregE == rtD));

		// branch or jr operand still being produced in E, or loaded in M
		branchstall = (branchD | jrD) &&
			((regwriteE && ((writeregE == rsD) || (writeregE == rtD))) ||
			(memtoregM && ((writeregM == rsD) || (writeregM == rtD))));

		// a redirect waits in decode while the pc is busy with a fetch
		redirectWait = (branchD | jumpD | jrD) & Iwait;
		holdD = lwstall | branchstall | redirectWait;

		// Dwait freezes every stage
		stallF = holdD | memstall | Iwait;
		stallD = holdD | memstall;
		stallE = memstall;
		stallM = memstall;
		stallW = memstall;

		// decode bubble on a missing fetch or the fetch after a redirect
		// never together with a hold or a freeze
		flushD = (Iwait | br_takenD | jumpD | jrD) & !holdD & !memstall;
		// held decode leaves a bubble in execute
		flushE = holdD & !memstall;
	end
endmodule : hazard_unit

// ==== source/bus_pkg.sv ====
// shared memory bus types
`include "core_macros.svh"

package bus_pkg;
	// word address, used for pc, data address and bus address
	typedef logic [`MEM_AW-1:0] memAddr_t;

	// owner of the memory bus
	typedef enum logic [1:0] {
		arbIdle,
		arbInstr,
		arbData
	} arbState_t;
endpackage

// ==== source/isa_pkg.sv ====
// instruction-set types for the integer subset
// opcode and funct encodings, alu operations, forward selects
`include "core_macros.svh"

package isa_pkg;
	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`REG_AW-1:0] regAddr_t;
	typedef logic [5:0] opcode_t;

	// primary opcodes, instr[31:26]
	localparam opcode_t opRType = 6'h00;
	localparam opcode_t opJ     = 6'h02;
	localparam opcode_t opBeq   = 6'h04;
	localparam opcode_t opBne   = 6'h05;
	localparam opcode_t opAddi  = 6'h08;
	localparam opcode_t opLw    = 6'h23;
	localparam opcode_t opSw    = 6'h2b;

	// r-type funct codes, instr[5:0], same width as an opcode
	localparam opcode_t fnJr  = 6'h08;
	localparam opcode_t fnAdd = 6'h20;
	localparam opcode_t fnSub = 6'h22;
	localparam opcode_t fnAnd = 6'h24;
	localparam opcode_t fnOr  = 6'h25;
	localparam opcode_t fnSlt = 6'h2a;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_t;

	// execute-stage operand source
	localparam logic [1:0] fwdReg     = 2'b00;
	localparam logic [1:0] fwdResultW = 2'b01;
	localparam logic [1:0] fwdAluOutM = 2'b10;
endpackage

// ==== source/core_macros.svh ====
// core-wide widths, register count and memory map
// shared by the packages and the pipeline core

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path word width
`define DATA_W 32

// register file
`define REG_AW 5
`define REG_COUNT 32

// memory holds 2**MEM_AW words, code and data share it
`define MEM_AW 10
`define MEM_WORDS 1024

// word address of the first fetch after reset
`define RESET_PC 0

`endif
